//--- source/hip_app_pkg.sv
package hip_app_pkg;

   // Avalon-ST stream widths, 64-bit interface only
   localparam int DATA_WIDTH = 64;
   localparam int BAR_WIDTH  = 8;

   // hard IP status field widths
   localparam int LTSSM_WIDTH      = 5;
   localparam int LANE_ACT_WIDTH   = 4;
   localparam int INT_STATUS_WIDTH = 4;

   // LTSSM code for L0, link up and usable
   localparam logic [LTSSM_WIDTH-1:0] LTSSM_L0 = 5'h0F;

   // link must sit in L0 this long before the application leaves reset
   localparam int APP_RST_HOLD_CYCLES = 32;
   localparam int APP_RST_CNT_WIDTH   = 6;

   // depth of the reset release synchronizer
   localparam int RST_SYNC_STAGES = 3;

   // register depth between rx and tx stream ports
   localparam int LOOPBACK_STAGES = 2;

endpackage

//--- source/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
   input  logic pld_clk,
   input  logic reset_status,
   output logic reset_status_sync_pldclk
);
   import hip_app_pkg::*;

   logic [RST_SYNC_STAGES-1:0] sync_q;

   // preset by the raw reset, zeros shift toward the output after release
   always_ff @(posedge pld_clk or posedge reset_status) begin
      if (reset_status) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b0};
      end
   end

   // asserts at once, releases on the last stage
   assign reset_status_sync_pldclk = sync_q[RST_SYNC_STAGES-1];

endmodule

//--- source/hip_status_regs.sv
`timescale 1ns/1ps

module hip_status_regs (
   input  logic                                     pld_clk,
   input  logic                                     reset_status_sync_pldclk,
   input  logic                                     derr_cor_ext_rcv,
   input  logic                                     derr_cor_ext_rpl,
   input  logic                                     derr_rpl,
   input  logic                                     dlup_exit,
   input  logic                                     ev128ns,
   input  logic                                     ev1us,
   input  logic                                     hotrst_exit,
   input  logic                                     l2_exit,
   input  logic [hip_app_pkg::INT_STATUS_WIDTH-1:0] int_status,
   input  logic [hip_app_pkg::LANE_ACT_WIDTH-1:0]   lane_act,
   input  logic [hip_app_pkg::LTSSM_WIDTH-1:0]      ltssmstate,
   output logic                                     derr_cor_ext_rcv_drv,
   output logic                                     derr_cor_ext_rpl_drv,
   output logic                                     derr_rpl_drv,
   output logic                                     dlup_exit_drv,
   output logic                                     ev128ns_drv,
   output logic                                     ev1us_drv,
   output logic                                     hotrst_exit_drv,
   output logic                                     l2_exit_drv,
   output logic [hip_app_pkg::INT_STATUS_WIDTH-1:0] int_status_drv,
   output logic [hip_app_pkg::LANE_ACT_WIDTH-1:0]   lane_act_drv,
   output logic [hip_app_pkg::LTSSM_WIDTH-1:0]      ltssmstate_drv
);

   // one register level, hard IP status moved onto pld_clk
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         derr_cor_ext_rcv_drv <= 1'b0;
         derr_cor_ext_rpl_drv <= 1'b0;
         derr_rpl_drv         <= 1'b0;
         ev128ns_drv          <= 1'b0;
         ev1us_drv            <= 1'b0;
         int_status_drv       <= '0;
         lane_act_drv         <= '0;
      end else begin
         derr_cor_ext_rcv_drv <= derr_cor_ext_rcv;
         derr_cor_ext_rpl_drv <= derr_cor_ext_rpl;
         derr_rpl_drv         <= derr_rpl;
         ev128ns_drv          <= ev128ns;
         ev1us_drv            <= ev1us;
         int_status_drv       <= int_status;
         lane_act_drv         <= lane_act;
      end
   end

   // link state fields, also watched by the reset sequencer
   // exit flags are active low, so the cleared value reads as an exit
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         dlup_exit_drv   <= 1'b0;
         hotrst_exit_drv <= 1'b0;
         l2_exit_drv     <= 1'b0;
         ltssmstate_drv  <= '0;
      end else begin
         dlup_exit_drv   <= dlup_exit;
         hotrst_exit_drv <= hotrst_exit;
         l2_exit_drv     <= l2_exit;
         ltssmstate_drv  <= ltssmstate;
      end
   end

endmodule

//--- source/app_reset_seq.sv
`timescale 1ns/1ps

module app_reset_seq (
   input  logic                                pld_clk,
   input  logic                                reset_status_sync_pldclk,
   input  logic                                pld_clk_inuse,
   input  logic [hip_app_pkg::LTSSM_WIDTH-1:0] ltssmstate_drv,
   input  logic                                dlup_exit_drv,
   input  logic                                hotrst_exit_drv,
   input  logic                                l2_exit_drv,
   output logic                                app_rstn
);
   import hip_app_pkg::*;

   localparam logic [APP_RST_CNT_WIDTH-1:0] HOLD_MAX = APP_RST_CNT_WIDTH'(APP_RST_HOLD_CYCLES);

   logic                         clk_inuse_q;
   logic                         link_ok;
   logic [APP_RST_CNT_WIDTH-1:0] hold_cnt;

   // clock-in-use flag gets the same one-cycle retiming as the hard IP status
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         clk_inuse_q <= 1'b0;
      end else begin
         clk_inuse_q <= pld_clk_inuse;
      end
   end

   // usable link: core clock running, in L0, no exit pulse (all active low)
   assign link_ok = clk_inuse_q
                  && (ltssmstate_drv == LTSSM_L0)
                  && dlup_exit_drv
                  && hotrst_exit_drv
                  && l2_exit_drv;

   // count consecutive usable cycles, saturate at the hold time
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         hold_cnt <= '0;
      end else if (!link_ok) begin
         hold_cnt <= '0;
      end else if (hold_cnt != HOLD_MAX) begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

   // release one edge after the count is full
   // any bad cycle pulls the reset back in on the next edge
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         app_rstn <= 1'b0;
      end else begin
         app_rstn <= link_ok && (hold_cnt == HOLD_MAX);
      end
   end

endmodule

//--- source/ast_loopback.sv
`timescale 1ns/1ps

module ast_loopback (
   input  logic                               pld_clk,
   input  logic                               reset_status_sync_pldclk,
   input  logic [hip_app_pkg::DATA_WIDTH-1:0] rx_st_data,
   input  logic                               rx_st_sop,
   input  logic                               rx_st_eop,
   input  logic                               rx_st_valid,
   output logic [hip_app_pkg::DATA_WIDTH-1:0] tx_st_data,
   output logic                               tx_st_sop,
   output logic                               tx_st_eop,
   output logic                               tx_st_valid
);
   import hip_app_pkg::*;

   logic [DATA_WIDTH-1:0] data_q  [LOOPBACK_STAGES];
   logic                  sop_q   [LOOPBACK_STAGES];
   logic                  eop_q   [LOOPBACK_STAGES];
   logic                  valid_q [LOOPBACK_STAGES];

   // payload pipe, carries whatever sits on the bus
   always_ff @(posedge pld_clk) begin
      data_q[0] <= rx_st_data;
      for (int i = 1; i < LOOPBACK_STAGES; i++) begin
         data_q[i] <= data_q[i-1];
      end
   end

   // framing and valid pipe
   // no tx_st_ready here, the loopback never stalls
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         for (int i = 0; i < LOOPBACK_STAGES; i++) begin
            sop_q[i]   <= 1'b0;
            eop_q[i]   <= 1'b0;
            valid_q[i] <= 1'b0;
         end
      end else begin
         sop_q[0]   <= rx_st_sop;
         eop_q[0]   <= rx_st_eop;
         valid_q[0] <= rx_st_valid;
         for (int i = 1; i < LOOPBACK_STAGES; i++) begin
            sop_q[i]   <= sop_q[i-1];
            eop_q[i]   <= eop_q[i-1];
            valid_q[i] <= valid_q[i-1];
         end
      end
   end

   // last stage drives the transmit side
   assign tx_st_data  = data_q[LOOPBACK_STAGES-1];
   assign tx_st_sop   = sop_q[LOOPBACK_STAGES-1];
   assign tx_st_eop   = eop_q[LOOPBACK_STAGES-1];
   assign tx_st_valid = valid_q[LOOPBACK_STAGES-1];

endmodule

//--- source/hip_app_top.sv
`timescale 1ns/1ps

module hip_app_top (
   input  logic                                     pld_clk,
   input  logic                                     reset_status,
   input  logic                                     pld_clk_inuse,

   // hard IP status in
   input  logic                                     derr_cor_ext_rcv,
   input  logic                                     derr_cor_ext_rpl,
   input  logic                                     derr_rpl,
   input  logic                                     dlup_exit,
   input  logic                                     ev128ns,
   input  logic                                     ev1us,
   input  logic                                     hotrst_exit,
   input  logic                                     l2_exit,
   input  logic [hip_app_pkg::INT_STATUS_WIDTH-1:0] int_status,
   input  logic [hip_app_pkg::LANE_ACT_WIDTH-1:0]   lane_act,
   input  logic [hip_app_pkg::LTSSM_WIDTH-1:0]      ltssmstate,

   // registered status out
   output logic                                     derr_cor_ext_rcv_drv,
   output logic                                     derr_cor_ext_rpl_drv,
   output logic                                     derr_rpl_drv,
   output logic                                     dlup_exit_drv,
   output logic                                     ev128ns_drv,
   output logic                                     ev1us_drv,
   output logic                                     hotrst_exit_drv,
   output logic                                     l2_exit_drv,
   output logic [hip_app_pkg::INT_STATUS_WIDTH-1:0] int_status_drv,
   output logic [hip_app_pkg::LANE_ACT_WIDTH-1:0]   lane_act_drv,
   output logic [hip_app_pkg::LTSSM_WIDTH-1:0]      ltssmstate_drv,

   // Avalon-ST receive and transmit
   input  logic [hip_app_pkg::DATA_WIDTH-1:0]       rx_st_data,
   input  logic                                     rx_st_sop,
   input  logic                                     rx_st_eop,
   input  logic                                     rx_st_valid,
   output logic [hip_app_pkg::DATA_WIDTH-1:0]       tx_st_data,
   output logic                                     tx_st_sop,
   output logic                                     tx_st_eop,
   output logic                                     tx_st_valid,

   output logic                                     app_rstn
);

   logic reset_status_sync_pldclk;

   reset_sync u_reset_sync (
      .pld_clk                  (pld_clk),
      .reset_status             (reset_status),
      .reset_status_sync_pldclk (reset_status_sync_pldclk)
   );

   hip_status_regs u_status_regs (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .derr_cor_ext_rcv         (derr_cor_ext_rcv),
      .derr_cor_ext_rpl         (derr_cor_ext_rpl),
      .derr_rpl                 (derr_rpl),
      .dlup_exit                (dlup_exit),
      .ev128ns                  (ev128ns),
      .ev1us                    (ev1us),
      .hotrst_exit              (hotrst_exit),
      .l2_exit                  (l2_exit),
      .int_status               (int_status),
      .lane_act                 (lane_act),
      .ltssmstate               (ltssmstate),
      .derr_cor_ext_rcv_drv     (derr_cor_ext_rcv_drv),
      .derr_cor_ext_rpl_drv     (derr_cor_ext_rpl_drv),
      .derr_rpl_drv             (derr_rpl_drv),
      .dlup_exit_drv            (dlup_exit_drv),
      .ev128ns_drv              (ev128ns_drv),
      .ev1us_drv                (ev1us_drv),
      .hotrst_exit_drv          (hotrst_exit_drv),
      .l2_exit_drv              (l2_exit_drv),
      .int_status_drv           (int_status_drv),
      .lane_act_drv             (lane_act_drv),
      .ltssmstate_drv           (ltssmstate_drv)
   );

   // sequencer sees only the retimed link state
   app_reset_seq u_app_reset_seq (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .pld_clk_inuse            (pld_clk_inuse),
      .ltssmstate_drv           (ltssmstate_drv),
      .dlup_exit_drv            (dlup_exit_drv),
      .hotrst_exit_drv          (hotrst_exit_drv),
      .l2_exit_drv              (l2_exit_drv),
      .app_rstn                 (app_rstn)
   );

   ast_loopback u_loopback (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .rx_st_data               (rx_st_data),
      .rx_st_sop                (rx_st_sop),
      .rx_st_eop                (rx_st_eop),
      .rx_st_valid              (rx_st_valid),
      .tx_st_data               (tx_st_data),
      .tx_st_sop                (tx_st_sop),
      .tx_st_eop                (tx_st_eop),
      .tx_st_valid              (tx_st_valid)
   );

endmodule

//--- verif/tb_hip_app.sv
`timescale 1ns/1ps

module tb_hip_app;
   import hip_app_pkg::*;

   localparam int CLK_PERIOD     = 100;
   localparam int DRIVE_DELAY    = 10;
   localparam int RESET_CYCLES   = 2;
   localparam int RANDOM_CYCLES  = 200;
   localparam int LINKUP_CYCLES  = APP_RST_HOLD_CYCLES + 16;
   localparam int RECOVER_CYCLES = APP_RST_HOLD_CYCLES + 8;
   localparam int EXIT_EVENTS    = 5;
   localparam int SETTLE_CYCLES  = LOOPBACK_STAGES + 2;
   localparam int TOTAL_CYCLES   = RESET_CYCLES + RANDOM_CYCLES + LINKUP_CYCLES
                                 + EXIT_EVENTS * (RECOVER_CYCLES + 1) + SETTLE_CYCLES;
   localparam int STATUS_BITS    = 8 + INT_STATUS_WIDTH + LANE_ACT_WIDTH + LTSSM_WIDTH;
   localparam int STREAM_BITS    = DATA_WIDTH + 3;

   logic                        pld_clk;
   logic                        reset_status;
   logic                        pld_clk_inuse;
   logic                        derr_cor_ext_rcv;
   logic                        derr_cor_ext_rpl;
   logic                        derr_rpl;
   logic                        dlup_exit;
   logic                        ev128ns;
   logic                        ev1us;
   logic                        hotrst_exit;
   logic                        l2_exit;
   logic [INT_STATUS_WIDTH-1:0] int_status;
   logic [LANE_ACT_WIDTH-1:0]   lane_act;
   logic [LTSSM_WIDTH-1:0]      ltssmstate;
   logic                        derr_cor_ext_rcv_drv;
   logic                        derr_cor_ext_rpl_drv;
   logic                        derr_rpl_drv;
   logic                        dlup_exit_drv;
   logic                        ev128ns_drv;
   logic                        ev1us_drv;
   logic                        hotrst_exit_drv;
   logic                        l2_exit_drv;
   logic [INT_STATUS_WIDTH-1:0] int_status_drv;
   logic [LANE_ACT_WIDTH-1:0]   lane_act_drv;
   logic [LTSSM_WIDTH-1:0]      ltssmstate_drv;
   logic [DATA_WIDTH-1:0]       rx_st_data;
   logic                        rx_st_sop;
   logic                        rx_st_eop;
   logic                        rx_st_valid;
   logic [DATA_WIDTH-1:0]       tx_st_data;
   logic                        tx_st_sop;
   logic                        tx_st_eop;
   logic                        tx_st_valid;
   logic                        app_rstn;

   logic [STATUS_BITS-1:0]      status_in;
   logic [STATUS_BITS-1:0]      status_out;
   logic [STREAM_BITS-1:0]      stream_in;
   logic [STREAM_BITS-1:0]      stream_out;
   logic                        qual_in;
   logic                        rstn_exp = 1'b0;
   logic                        rstn_last = 1'b0;
   int                          rel_cnt = 0;
   int                          qual_run = 0;
   int                          rstn_rises = 0;
   int                          errors = 0;
   int                          seed = 32'h61912646;

   hip_app_top UUT (.*);

   initial begin
      pld_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pld_clk = ~pld_clk;
   end

   assign status_in  = {derr_cor_ext_rcv, derr_cor_ext_rpl, derr_rpl, dlup_exit, ev128ns,
                        ev1us, hotrst_exit, l2_exit, int_status, lane_act, ltssmstate};
   assign status_out = {derr_cor_ext_rcv_drv, derr_cor_ext_rpl_drv, derr_rpl_drv,
                        dlup_exit_drv, ev128ns_drv, ev1us_drv, hotrst_exit_drv, l2_exit_drv,
                        int_status_drv, lane_act_drv, ltssmstate_drv};
   assign stream_in  = {rx_st_data, rx_st_sop, rx_st_eop, rx_st_valid};
   assign stream_out = {tx_st_data, tx_st_sop, tx_st_eop, tx_st_valid};

   // usable link as seen at the hard IP pins
   assign qual_in = pld_clk_inuse && (ltssmstate == LTSSM_L0)
                  && dlup_exit && hotrst_exit && l2_exit;

   // edges since reset_status fell
   always @(posedge pld_clk) begin
      if (reset_status) begin
         rel_cnt <= 0;
      end else begin
         rel_cnt <= rel_cnt + 1;
      end
   end

   // expected app_rstn after the hold time plus the status and output registers
   always @(posedge pld_clk) begin
      if (!qual_in || rel_cnt < RST_SYNC_STAGES) begin
         qual_run <= 0;
      end else begin
         qual_run <= qual_run + 1;
      end
      rstn_exp <= (qual_run >= APP_RST_HOLD_CYCLES + 1);
   end

   always @(posedge pld_clk) begin
      rstn_last <= app_rstn;
      if (app_rstn && !rstn_last) begin
         rstn_rises <= rstn_rises + 1;
      end
   end

   task automatic note_failure(input string msg);
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   chk_reset_out: assert property (@(posedge pld_clk)
      (rel_cnt <= RST_SYNC_STAGES + 1)
         |-> (!tx_st_valid && !tx_st_sop && !tx_st_eop && !app_rstn))
      else note_failure("stream control or app_rstn active during reset");

   chk_status_reset: assert property (@(posedge pld_clk)
      (rel_cnt <= RST_SYNC_STAGES) |-> (status_out == '0))
      else note_failure("status outputs not cleared during reset");

   chk_status: assert property (@(posedge pld_clk)
      (rel_cnt >= RST_SYNC_STAGES + 1) |-> (status_out == $past(status_in)))
      else note_failure("status output differs from input one cycle earlier");

   chk_loopback: assert property (@(posedge pld_clk)
      (rel_cnt >= RST_SYNC_STAGES + 2) |-> (stream_out == $past(stream_in, LOOPBACK_STAGES)))
      else note_failure("transmit beat differs from received beat");

   chk_app_rstn: assert property (@(posedge pld_clk) app_rstn == rstn_exp)
      else note_failure($sformatf("app_rstn is %b, expected %b", app_rstn, rstn_exp));

   task automatic next_drive_point();
      @(posedge pld_clk);
      #DRIVE_DELAY;
   endtask

   task automatic randomize_status();
      logic [31:0] r;
      r = $random(seed);
      derr_cor_ext_rcv = r[0];
      derr_cor_ext_rpl = r[1];
      derr_rpl         = r[2];
      ev128ns          = r[3];
      ev1us            = r[4];
      int_status       = r[11:8];
      lane_act         = r[15:12];
   endtask

   // L0 half the time so partial link-up runs also occur
   task automatic randomize_link();
      logic [31:0] r;
      r = $random(seed);
      dlup_exit     = r[0] | r[10];
      hotrst_exit   = r[1] | r[11];
      l2_exit       = r[2] | r[12];
      pld_clk_inuse = r[3];
      ltssmstate    = r[9] ? LTSSM_L0 : r[8:4];
   endtask

   task automatic set_link(input logic [LTSSM_WIDTH-1:0] state, input logic dl,
                           input logic hr, input logic l2, input logic inuse);
      ltssmstate    = state;
      dlup_exit     = dl;
      hotrst_exit   = hr;
      l2_exit       = l2;
      pld_clk_inuse = inuse;
   endtask

   // burst mode sends a valid beat every cycle in four-beat packets
   task automatic drive_beat(input logic burst, input int beat);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      rx_st_data = {hi, lo};
      if (burst) begin
         rx_st_valid = 1'b1;
         rx_st_sop   = (beat % 4 == 0);
         rx_st_eop   = (beat % 4 == 3);
      end else begin
         rx_st_valid = lo[0];
         rx_st_sop   = lo[1];
         rx_st_eop   = lo[2];
      end
   endtask

   initial begin
      reset_status = 1'b1;
      set_link('0, 1'b0, 1'b0, 1'b0, 1'b0);
      derr_cor_ext_rcv = 1'b0;
      derr_cor_ext_rpl = 1'b0;
      derr_rpl         = 1'b0;
      ev128ns          = 1'b0;
      ev1us            = 1'b0;
      int_status       = '0;
      lane_act         = '0;
      rx_st_data       = '0;
      rx_st_sop        = 1'b0;
      rx_st_eop        = 1'b0;
      rx_st_valid      = 1'b0;

      repeat (RESET_CYCLES) @(posedge pld_clk);
      #DRIVE_DELAY;
      reset_status = 1'b0;

      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         next_drive_point();
         randomize_status();
         randomize_link();
         drive_beat(1'b0, i);
      end

      // link up and stable so app_rstn must release
      for (int i = 0; i < LINKUP_CYCLES; i++) begin
         next_drive_point();
         randomize_status();
         set_link(LTSSM_L0, 1'b1, 1'b1, 1'b1, 1'b1);
         drive_beat(1'b1, i);
      end

      // one bad cycle each for dlup, hotrst, l2, non-L0 code and clock not in use
      for (int ev = 0; ev < EXIT_EVENTS; ev++) begin
         next_drive_point();
         randomize_status();
         set_link((ev == 3) ? (LTSSM_L0 ^ 5'h01) : LTSSM_L0,
                  ev != 0, ev != 1, ev != 2, ev != 4);
         drive_beat(1'b0, 0);
         for (int i = 0; i < RECOVER_CYCLES; i++) begin
            next_drive_point();
            randomize_status();
            set_link(LTSSM_L0, 1'b1, 1'b1, 1'b1, 1'b1);
            drive_beat(1'b1, i);
         end
      end

      for (int i = 0; i < SETTLE_CYCLES; i++) begin
         next_drive_point();
         rx_st_valid = 1'b0;
         rx_st_sop   = 1'b0;
         rx_st_eop   = 1'b0;
      end

      chk_release_count: assert (rstn_rises == EXIT_EVENTS + 1)
         else note_failure($sformatf("app_rstn released %0d times, expected %0d",
                                     rstn_rises, EXIT_EVENTS + 1));

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // watchdog ends the run after its full length plus margin
   initial begin
      #((TOTAL_CYCLES + 50) * CLK_PERIOD);
      $display("timeout: testbench did not finish within %0d cycles", TOTAL_CYCLES + 50);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- verilog.f
source/hip_app_pkg.sv
source/reset_sync.sv
source/hip_status_regs.sv
source/app_reset_seq.sv
source/ast_loopback.sv
source/hip_app_top.sv
verif/tb_hip_app.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_hip_app -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_hip_app)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
echo "pass line not found"
exit 1
